/* hdl/matrix_dec_pkg.sv */
// Shared region map, port codes, response codes and bus structs; imported by every decoder block

package matrix_dec_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    localparam integer NUM_PORTS  = 6;     // Output ports behind this decoder
    localparam integer DEC_ADDR_W = 22;    // HADDR[31:10]
    localparam integer DATA_W     = 32;    // Read data width

    // --------------------------------------------------
    // Region map
    // --------------------------------------------------
    // Bounds are inclusive, in 1 KB units, so 0x20000000 shows up as 22'h080000
    // Entry 0 belongs to port 1
    localparam logic [DEC_ADDR_W-1:0] REGION_BASE [0:NUM_PORTS-1] = '{
        22'h080000,    // 0x20000000
        22'h0c0000,    // 0x30000000
        22'h100000,    // 0x40000000
        22'h140000,    // 0x50000000
        22'h180000,    // 0x60000000
        22'h1c0000     // 0x70000000
    };

    localparam logic [DEC_ADDR_W-1:0] REGION_LIMIT [0:NUM_PORTS-1] = '{
        22'h0800bf,    // 0x2002ffff, 192 KB
        22'h0c000f,    // 0x30003fff, 16 KB
        22'h10013f,    // 0x4004ffff, 320 KB
        22'h1401ff,    // 0x5007ffff, 512 KB
        22'h18007f,    // 0x6001ffff, 128 KB
        22'h1c007f     // 0x7001ffff, 128 KB
    };

    // AHB response codes
    localparam logic [1:0] RESP_OKAY  = 2'b00;
    localparam logic [1:0] RESP_ERROR = 2'b01;

    // --------------------------------------------------
    // Codes
    // --------------------------------------------------
    typedef enum logic [3:0] {
        PORT_1   = 4'd1,
        PORT_2   = 4'd2,
        PORT_3   = 4'd3,
        PORT_4   = 4'd4,
        PORT_5   = 4'd5,
        PORT_6   = 4'd6,
        PORT_DFT = 4'd8    // Local default slave
    } port_t;

    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'b00,
        TRANS_BUSY   = 2'b01,
        TRANS_NONSEQ = 2'b10,
        TRANS_SEQ    = 2'b11
    } htrans_t;

    // --------------------------------------------------
    // Bus bundles
    // --------------------------------------------------
    // Address phase from the input stage, 25 bits
    typedef struct packed {
        logic                  hsel;
        logic [DEC_ADDR_W-1:0] decode_addr;    // HADDR[31:10]
        htrans_t               htrans;
    } addr_phase_t;

    // What one output stage hands back, 36 bits
    typedef struct packed {
        logic              active;       // Output stage busy with this input
        logic              hreadyout;
        logic [1:0]        hresp;
        logic [DATA_W-1:0] hrdata;
    } slave_resp_t;

    // Default slave response, no data
    typedef struct packed {
        logic       hreadyout;
        logic [1:0] hresp;
    } dft_resp_t;

endpackage

/* hdl/matrix_addr_decode.sv */
// Address-phase decode of one matrix input port; turns HADDR[31:10] into a port code and selects

`timescale 1ns/100ps

module matrix_addr_decode
    import matrix_dec_pkg::*;
(
    input  addr_phase_t          addr_phase,      // hsel, address field, htrans
    input  port_t                data_port,       // Port owning the current data phase
    input  logic [NUM_PORTS-1:0] slave_active,    // Active flags of the output stages
    output port_t                addr_port,       // Port chosen for this address phase
    output logic [NUM_PORTS-1:0] hsel_slave,      // One-hot output stage selects
    output logic                 dft_sel,         // Default slave select
    output logic                 active           // Active flag of the chosen port
);

    // --------------------------------------------------
    // Region compare
    // --------------------------------------------------
    logic [NUM_PORTS-1:0] region_hit;    // Address inside region
    logic [NUM_PORTS-1:0] idle_hold;     // IDLE stays on data-phase owner
    logic [NUM_PORTS-1:0] port_hit;      // Either of the above
    logic                 trans_idle;

    assign trans_idle = (addr_phase.htrans == TRANS_IDLE);

    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            region_hit[i] = (addr_phase.decode_addr >= REGION_BASE[i]) &&
                            (addr_phase.decode_addr <= REGION_LIMIT[i]);
            // An IDLE must not pull the bus away from the port still in its data phase
            idle_hold[i]  = trans_idle && (data_port == port_t'(4'(i + 1)));
        end
    end

    assign port_hit = region_hit | idle_hold;

    // --------------------------------------------------
    // Priority encode, lowest port wins
    // --------------------------------------------------
    always_comb
    begin
        addr_port = PORT_DFT;    // Nothing matched
        // Walk downwards so the lowest hit is written last
        for (int i = NUM_PORTS - 1; i >= 0; i--)
        begin
            if (port_hit[i])
            begin
                addr_port = port_t'(4'(i + 1));
            end
        end
    end

    // --------------------------------------------------
    // Selects
    // --------------------------------------------------
    always_comb
    begin
        hsel_slave = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            // Gated by hsel from the input stage
            hsel_slave[i] = addr_phase.hsel && (addr_port == port_t'(4'(i + 1)));
        end
    end

    assign dft_sel = addr_phase.hsel && (addr_port == PORT_DFT);

    // --------------------------------------------------
    // Active mux
    // --------------------------------------------------
    always_comb
    begin
        active = 1'b1;    // Default slave is always ready to take it
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (addr_port == port_t'(4'(i + 1)))
            begin
                active = slave_active[i];
            end
        end
    end

endmodule

/* hdl/matrix_resp_mux.sv */
// Data-phase port register and response steering of one matrix input port

`timescale 1ns/100ps

module matrix_resp_mux
    import matrix_dec_pkg::*;
(
    input  logic              HCLK,
    input  logic              HRESETn,
    input  logic              hready,                     // Transfer done at input stage
    input  port_t             addr_port,                  // From the address decode
    input  slave_resp_t       slave_resp [NUM_PORTS],     // Output stage responses
    input  dft_resp_t         dft_resp,                   // Default slave response
    output port_t             data_port,                  // Owner of the data phase
    output logic              hreadyout,
    output logic [1:0]        hresp,
    output logic [DATA_W-1:0] hrdata
);

    // --------------------------------------------------
    // Data-phase port register
    // --------------------------------------------------
    // Loads on hready rather than hreadyout, since the input stage may complete
    // a transfer from its holding register while the slave still stalls
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            data_port <= PORT_DFT;    // Idle default slave gives ready and OKAY
        end
        else if (hready)
        begin
            data_port <= addr_port;
        end
    end

    // --------------------------------------------------
    // Ready mux
    // --------------------------------------------------
    always_comb
    begin
        hreadyout = dft_resp.hreadyout;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (data_port == port_t'(4'(i + 1)))
            begin
                hreadyout = slave_resp[i].hreadyout;
            end
        end
    end

    // Response mux
    always_comb
    begin
        hresp = dft_resp.hresp;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (data_port == port_t'(4'(i + 1)))
            begin
                hresp = slave_resp[i].hresp;
            end
        end
    end

    // Read data mux
    always_comb
    begin
        hrdata = '0;    // Default slave drives no data
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (data_port == port_t'(4'(i + 1)))
            begin
                hrdata = slave_resp[i].hrdata;
            end
        end
    end

endmodule

/* hdl/matrix_default_slave.sv */
// Local default slave; answers unmapped active transfers with the two-cycle AHB ERROR

`timescale 1ns/100ps

module matrix_default_slave
    import matrix_dec_pkg::*;
(
    input  logic      HCLK,
    input  logic      HRESETn,
    input  logic      hsel,        // From the address decode
    input  htrans_t   htrans,
    input  logic      hready,      // Transfer done at input stage
    output dft_resp_t dft_resp
);

    // --------------------------------------------------
    // State
    // --------------------------------------------------
    // Two-bit state, upper bit is the error flag, lower bit is hreadyout
    typedef enum logic [1:0] {
        DFT_IDLE = 2'b01,    // Zero-wait OKAY
        DFT_ERR1 = 2'b10,    // First ERROR cycle, wait state
        DFT_ERR2 = 2'b11     // Second ERROR cycle, ready
    } dft_state_t;

    dft_state_t state;
    dft_state_t state_nxt;
    logic       trans_req;    // Active transfer accepted this cycle

    // NONSEQ and SEQ both have htrans[1] set
    assign trans_req = hsel && hready &&
                       ((htrans == TRANS_NONSEQ) || (htrans == TRANS_SEQ));

    always_comb
    begin
        if (trans_req)
        begin
            state_nxt = DFT_ERR1;
        end
        else if (state == DFT_ERR1)
        begin
            state_nxt = DFT_ERR2;    // Finish the pair
        end
        else
        begin
            state_nxt = DFT_IDLE;
        end
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            state <= DFT_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    // Outputs straight from the state bits
    assign dft_resp.hreadyout = state[0];
    assign dft_resp.hresp     = state[1] ? RESP_ERROR : RESP_OKAY;

endmodule

/* hdl/matrix_decoder.sv */
// Top level of the input-port decoder; ties address decode, default slave and response mux together

`timescale 1ns/100ps

module matrix_decoder
    import matrix_dec_pkg::*;
(
    input  logic                 HCLK,
    input  logic                 HRESETn,
    input  logic                 hready,                  // Transfer done at input stage
    input  addr_phase_t          addr_phase,
    input  slave_resp_t          slave_resp [NUM_PORTS],  // One per output stage
    output logic [NUM_PORTS-1:0] hsel_slave,
    output logic                 active,
    output logic                 hreadyout,
    output logic [1:0]           hresp,
    output logic [DATA_W-1:0]    hrdata
);

    // --------------------------------------------------
    // Internal nets
    // --------------------------------------------------
    port_t                addr_port;       // Address phase port
    port_t                data_port;       // Data phase port
    logic [NUM_PORTS-1:0] slave_active;    // Active bits pulled out of slave_resp
    logic                 dft_sel;
    dft_resp_t            dft_resp;

    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            slave_active[i] = slave_resp[i].active;
        end
    end

    // Address phase
    matrix_addr_decode u_addr_decode (
        .addr_phase   (addr_phase),
        .data_port    (data_port),
        .slave_active (slave_active),
        .addr_port    (addr_port),
        .hsel_slave   (hsel_slave),
        .dft_sel      (dft_sel),
        .active       (active)
    );

    // Unmapped addresses land here
    matrix_default_slave u_default_slave (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .hsel     (dft_sel),
        .htrans   (addr_phase.htrans),
        .hready   (hready),
        .dft_resp (dft_resp)
    );

    // Data phase
    matrix_resp_mux u_resp_mux (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .hready     (hready),
        .addr_port  (addr_port),
        .slave_resp (slave_resp),
        .dft_resp   (dft_resp),
        .data_port  (data_port),
        .hreadyout  (hreadyout),
        .hresp      (hresp),
        .hrdata     (hrdata)
    );

endmodule

/* verif/matrix_decoder_properties.sv */
// Concurrent checks on the decoder top level; attached to every matrix_decoder through bind

`timescale 1ns/100ps

module matrix_decoder_properties
    import matrix_dec_pkg::*;
(
    input logic                 HCLK,
    input logic                 HRESETn,
    input addr_phase_t          addr_phase,
    input logic [NUM_PORTS-1:0] hsel_slave,
    input logic                 hreadyout,
    input logic [1:0]           hresp,
    input port_t                data_port     // Internal data-phase owner
);

    // --------------------------------------------------
    // Select checks
    // --------------------------------------------------
    sel_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
        $onehot0(hsel_slave))
        else $error("More than one slave select high: %b", hsel_slave);

    sel_gated: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !addr_phase.hsel |-> (hsel_slave == '0))
        else $error("Slave select high while hsel is low: %b", hsel_slave);

    // Default slave only stalls in the first ERROR cycle
    dft_wait_error: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (data_port == PORT_DFT && !hreadyout) |-> (hresp == RESP_ERROR))
        else $error("Default slave wait state without ERROR response");

endmodule

bind matrix_decoder matrix_decoder_properties u_properties (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .addr_phase (addr_phase),
    .hsel_slave (hsel_slave),
    .hreadyout  (hreadyout),
    .hresp      (hresp),
    .data_port  (data_port)
);

/* verif/tb_matrix_decoder.sv */
// Directed testbench for the input-port decoder; run as top with the RTL and the bound properties

`timescale 1ns/100ps

module tb_matrix_decoder;
    import matrix_dec_pkg::*;

    // --------------------------------------------------
    // DUT signals and testbench state
    // --------------------------------------------------
    logic                 HCLK;
    logic                 HRESETn;
    logic                 hready;                     // Input stage transfer done
    addr_phase_t          addr_phase;
    slave_resp_t          slave_resp [NUM_PORTS];     // Slave models
    logic [NUM_PORTS-1:0] hsel_slave;
    logic                 active;
    logic                 hreadyout;
    logic [1:0]           hresp;
    logic [DATA_W-1:0]    hrdata;

    integer               seed;
    logic [31:0]          rnd;
    int                   errors;
    int                   checks;
    int                   timeout_cycles = 20;        // Longest legal wait for hreadyout
    logic [NUM_PORTS-1:0] active_pattern = 6'b011010; // Mix of busy and idle output stages

    // Region bounds as byte addresses, entry 0 is port 1
    logic [31:0] base_addr [NUM_PORTS] = '{32'h2000_0000, 32'h3000_0000, 32'h4000_0000,
                                           32'h5000_0000, 32'h6000_0000, 32'h7000_0000};
    logic [31:0] limit_addr [NUM_PORTS] = '{32'h2002_ffff, 32'h3000_3fff, 32'h4004_ffff,
                                            32'h5007_ffff, 32'h6001_ffff, 32'h7001_ffff};

    matrix_decoder u_matrix_decoder (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .hready     (hready),
        .addr_phase (addr_phase),
        .slave_resp (slave_resp),
        .hsel_slave (hsel_slave),
        .active     (active),
        .hreadyout  (hreadyout),
        .hresp      (hresp),
        .hrdata     (hrdata)
    );

    initial
    begin
        HCLK = 1'b0;
        forever #5 HCLK = ~HCLK;    // 100 MHz
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Only HADDR[31:10] reaches the decoder
    task automatic drive_addr(input logic sel, input logic [31:0] byte_addr, input htrans_t trans);
        addr_phase.hsel        <= sel;
        addr_phase.decode_addr <= byte_addr[31:10];
        addr_phase.htrans      <= trans;
    endtask

    // Called at a falling edge, returns the wait states seen
    task automatic wait_ready(input string name, output int cycles);
        int n;
        n = 0;
        while (hreadyout !== 1'b1 && n < timeout_cycles)
        begin
            @(negedge HCLK);
            n++;
        end
        if (hreadyout !== 1'b1)
        begin
            errors++;
            $display("%s: hreadyout still low after %0d cycles", name, timeout_cycles);
        end
        cycles = n;
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_reset_deselect();
        int n;
        @(negedge HCLK);
        check("reset_deselect", 32'd1, 32'(hreadyout));
        check("reset_deselect", 32'(RESP_OKAY), 32'(hresp));
        check("reset_deselect", 32'd0, hrdata);
        for (int k = 0; k < NUM_PORTS; k++)
        begin
            @(posedge HCLK);
            drive_addr(1'b0, base_addr[k], TRANS_NONSEQ);    // Mapped, but hsel low
            @(negedge HCLK);
            check("reset_deselect", 32'd0, 32'(hsel_slave));
        end
        @(posedge HCLK);
        drive_addr(1'b1, 32'h0000_1000, TRANS_IDLE);    // Unmapped IDLE
        hready <= 1'b1;
        @(posedge HCLK);
        drive_addr(1'b0, 32'h0, TRANS_IDLE);
        @(negedge HCLK);
        wait_ready("reset_deselect", n);
        check("reset_deselect", 32'd0, 32'(n));    // Zero-wait
        check("reset_deselect", 32'(RESP_OKAY), 32'(hresp));
    endtask

    task automatic test_region_decode();
        logic [31:0]          points [3];
        logic [NUM_PORTS-1:0] exp_sel;
        logic                 exp_act;
        @(posedge HCLK);
        hready <= 1'b0;    // Address phases only, no data phase starts
        for (int k = 0; k < NUM_PORTS; k++)
        begin
            points[0] = base_addr[k];
            points[1] = limit_addr[k];
            points[2] = limit_addr[k] + 32'd1;    // First 1 KB unit past the region
            for (int p = 0; p < 3; p++)
            begin
                exp_sel    = '0;
                exp_sel[k] = (p < 2);
                exp_act    = (p < 2) ? slave_resp[k].active : 1'b1;
                @(posedge HCLK);
                drive_addr(1'b1, points[p], TRANS_NONSEQ);
                @(negedge HCLK);
                check("region_decode", 32'(exp_sel), 32'(hsel_slave));
                check("region_decode", 32'(exp_act), 32'(active));
            end
        end
        @(posedge HCLK);
        drive_addr(1'b0, 32'h0, TRANS_IDLE);
    endtask

    task automatic test_routing();
        int         n;
        logic [1:0] exp_resp;
        for (int k = 0; k < NUM_PORTS; k++)
        begin
            exp_resp = (k % 2 == 1) ? RESP_ERROR : RESP_OKAY;    // Ports 2, 4 and 6 fail
            @(posedge HCLK);
            drive_addr(1'b1, base_addr[k], TRANS_NONSEQ);
            hready <= 1'b1;
            @(posedge HCLK);                       // Data phase on port k from here
            drive_addr(1'b0, 32'h0, TRANS_IDLE);
            hready                  <= 1'b0;
            slave_resp[k].hreadyout <= 1'b0;       // Model inserts wait states
            repeat (2)
            begin
                @(negedge HCLK);
                check("routing", 32'd0, 32'(hreadyout));
                check("routing", slave_resp[k].hrdata, hrdata);
            end
            @(posedge HCLK);
            slave_resp[k].hresp <= exp_resp;       // Last wait state carries the response
            @(negedge HCLK);
            check("routing", 32'd0, 32'(hreadyout));
            check("routing", 32'(exp_resp), 32'(hresp));
            @(posedge HCLK);
            slave_resp[k].hreadyout <= 1'b1;
            @(negedge HCLK);
            wait_ready("routing", n);
            check("routing", 32'(exp_resp), 32'(hresp));
            check("routing", slave_resp[k].hrdata, hrdata);
            @(posedge HCLK);
            hready              <= 1'b1;           // Input stage completes
            slave_resp[k].hresp <= RESP_OKAY;
        end
    endtask

    task automatic test_default_slave();
        int n;
        @(posedge HCLK);
        drive_addr(1'b1, 32'h0000_1000, TRANS_NONSEQ);    // Below every region
        hready <= 1'b1;
        @(negedge HCLK);
        check("default_slave", 32'd0, 32'(hsel_slave));
        check("default_slave", 32'd1, 32'(active));
        @(posedge HCLK);
        drive_addr(1'b0, 32'h0, TRANS_IDLE);
        hready <= 1'b0;
        @(negedge HCLK);
        check("default_slave", 32'd0, 32'(hreadyout));
        check("default_slave", 32'(RESP_ERROR), 32'(hresp));
        check("default_slave", 32'd0, hrdata);
        wait_ready("default_slave", n);
        check("default_slave", 32'd1, 32'(n));    // One wait state
        check("default_slave", 32'(RESP_ERROR), 32'(hresp));
        check("default_slave", 32'd0, hrdata);
        @(posedge HCLK);
        hready <= 1'b1;
        @(negedge HCLK);
        check("default_slave", 32'(RESP_OKAY), 32'(hresp));
    endtask

    task automatic test_idle_hold();
        logic [NUM_PORTS-1:0] exp_sel;
        exp_sel    = '0;
        exp_sel[2] = 1'b1;    // Port 3
        @(posedge HCLK);
        drive_addr(1'b1, base_addr[2], TRANS_NONSEQ);
        hready <= 1'b1;
        @(posedge HCLK);
        drive_addr(1'b1, 32'h0000_1000, TRANS_IDLE);    // Unmapped IDLE
        hready <= 1'b0;
        @(negedge HCLK);
        check("idle_hold", 32'(exp_sel), 32'(hsel_slave));
        check("idle_hold", 32'(slave_resp[2].active), 32'(active));
        @(posedge HCLK);
        hready <= 1'b1;
        @(negedge HCLK);
        check("idle_hold", 32'(exp_sel), 32'(hsel_slave));    // Still port 3
        @(posedge HCLK);
        drive_addr(1'b0, 32'h0, TRANS_IDLE);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin
        seed   = 45;
        errors = 0;
        checks = 0;
        HRESETn    <= 1'b0;
        hready     <= 1'b0;
        addr_phase <= '0;
        for (int k = 0; k < NUM_PORTS; k++)
        begin
            rnd = $random(seed);
            slave_resp[k].active    <= active_pattern[k];
            slave_resp[k].hreadyout <= 1'b1;
            slave_resp[k].hresp     <= RESP_OKAY;
            slave_resp[k].hrdata    <= {8'(k + 1), rnd[23:0]};    // Port number on top
        end
        repeat (4) @(posedge HCLK);
        HRESETn <= 1'b1;
        test_reset_deselect();
        test_region_decode();
        test_routing();
        test_default_slave();
        test_idle_hold();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
hdl/matrix_dec_pkg.sv
hdl/matrix_addr_decode.sv
hdl/matrix_resp_mux.sv
hdl/matrix_default_slave.sv
hdl/matrix_decoder.sv
verif/matrix_decoder_properties.sv
verif/tb_matrix_decoder.sv

/* Makefile */
# Verilator build and run for the matrix input-port decoder

VERILATOR ?= verilator
TOP       ?= tb_matrix_decoder
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails on the fail message in the log, or on an abnormal simulator exit
run: compile
	@./$(SIM) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
